// File: source/ex_pkg.sv
package ex_pkg;

    localparam int DATA_W = 32;
    localparam int TAG_W  = 4;

    // Execute operations
    typedef enum logic [3:0] {
        OP_ADD     = 4'h0,
        OP_SUB     = 4'h1,
        OP_AND     = 4'h2,
        OP_OR      = 4'h3,
        OP_XOR     = 4'h4,
        OP_SLL     = 4'h5,
        OP_SRL     = 4'h6,
        OP_SLT     = 4'h7,
        OP_SLTU    = 4'h8,
        OP_ADDI    = 4'h9,
        OP_LDW     = 4'ha,
        OP_STW     = 4'hb,
        OP_BEQ     = 4'hc,
        OP_CSRXCHG = 4'hd,
        OP_MUL     = 4'he,
        OP_MULHU   = 4'hf
    } ex_op_e;

    typedef struct packed {
        logic [11:0] num;
    } csr_field_t;

    // Immediate for ADDI, memory and branch ops, CSR number for CSRXCHG
    typedef union packed {
        logic signed [11:0] imm;
        csr_field_t         csr;
    } op_aux_u;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        ex_op_e            op;
        logic [DATA_W-1:0] src1;
        logic [DATA_W-1:0] src2;
        logic [DATA_W-1:0] csr_old;
        op_aux_u           aux;
        logic [DATA_W-1:0] pc;
    } ex_uop_t;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] mem_addr;
        logic              excp_ale;
        logic              csr_we;
        logic [11:0]       csr_addr;
        logic [DATA_W-1:0] csr_wdata;
        logic              redirect;
        logic [DATA_W-1:0] redirect_target;
    } ex_result_t;

endpackage

// File: source/alu.sv
`timescale 1ns/1ns

module alu (
    input  ex_pkg::ex_op_e             op_i,
    input  logic [ex_pkg::DATA_W-1:0]  src1_i,
    input  logic [ex_pkg::DATA_W-1:0]  src2_i,
    input  logic [ex_pkg::DATA_W-1:0]  pc_i,
    input  ex_pkg::op_aux_u            aux_i,
    output logic [ex_pkg::DATA_W-1:0]  result_o,
    output logic [ex_pkg::DATA_W-1:0]  addr_o,
    output logic                       taken_o
);
    logic [ex_pkg::DATA_W-1:0] imm_ext;
    logic [ex_pkg::DATA_W-1:0] base;
    logic [4:0]                shamt;
    logic                      lt_signed;
    logic                      lt_unsigned;

    assign imm_ext = {{(ex_pkg::DATA_W - 12){aux_i.imm[11]}}, aux_i.imm};
    assign shamt   = src2_i[4:0];

    // One adder serves load/store addresses, ADDI and the branch target
    assign base    = (op_i == ex_pkg::OP_BEQ) ? pc_i : src1_i;
    assign addr_o  = base + imm_ext;
    assign taken_o = (op_i == ex_pkg::OP_BEQ) && (src1_i == src2_i);

    assign lt_signed   = $signed(src1_i) < $signed(src2_i);
    assign lt_unsigned = src1_i < src2_i;

    always_comb begin
        case (op_i)
            ex_pkg::OP_ADD:  result_o = src1_i + src2_i;
            ex_pkg::OP_SUB:  result_o = src1_i - src2_i;
            ex_pkg::OP_AND:  result_o = src1_i & src2_i;
            ex_pkg::OP_OR:   result_o = src1_i | src2_i;
            ex_pkg::OP_XOR:  result_o = src1_i ^ src2_i;
            ex_pkg::OP_SLL:  result_o = src1_i << shamt;
            ex_pkg::OP_SRL:  result_o = src1_i >> shamt;
            ex_pkg::OP_SLT:  result_o = {{(ex_pkg::DATA_W - 1){1'b0}}, lt_signed};
            ex_pkg::OP_SLTU: result_o = {{(ex_pkg::DATA_W - 1){1'b0}}, lt_unsigned};
            // Base is src1 here
            ex_pkg::OP_ADDI: result_o = addr_o;
            default:         result_o = '0;
        endcase
    end

endmodule

// File: source/mul_unit.sv
`timescale 1ns/1ns

module mul_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_i,
    input  logic                       high_i,
    input  logic [ex_pkg::DATA_W-1:0]  a_i,
    input  logic [ex_pkg::DATA_W-1:0]  b_i,
    output logic                       done_o,
    output logic [ex_pkg::DATA_W-1:0]  product_o
);
    localparam int CNT_W = $clog2(ex_pkg::DATA_W);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(ex_pkg::DATA_W - 1);

    // Upper half accumulates partial sums, lower half holds remaining multiplier bits
    logic [2*ex_pkg::DATA_W-1:0] acc_q;
    logic [ex_pkg::DATA_W-1:0]   mcand_q;
    logic [ex_pkg::DATA_W:0]     sum;
    logic [CNT_W-1:0]            count_q;
    logic                        busy_q;

    assign sum = {1'b0, acc_q[2*ex_pkg::DATA_W-1:ex_pkg::DATA_W]}
               + (acc_q[0] ? {1'b0, mcand_q} : '0);

    //////////////////////////////
    // Control
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            done_o  <= 1'b0;
            count_q <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy_q  <= 1'b1;
                count_q <= '0;
            end else if (busy_q) begin
                count_q <= count_q + 1'b1;
                if (count_q == LAST_STEP) begin
                    busy_q <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Datapath, one multiplier bit per step
    always_ff @(posedge clk) begin
        if (start_i) begin
            acc_q   <= {{ex_pkg::DATA_W{1'b0}}, b_i};
            mcand_q <= a_i;
        end else if (busy_q) begin
            acc_q <= {sum, acc_q[ex_pkg::DATA_W-1:1]};
        end
    end

    assign product_o = high_i ? acc_q[2*ex_pkg::DATA_W-1:ex_pkg::DATA_W]
                              : acc_q[ex_pkg::DATA_W-1:0];

endmodule

// File: source/ex_lane.sv
`timescale 1ns/1ns

module ex_lane (
    input  logic               clk,
    input  logic               rst,
    input  logic               start_i,
    input  ex_pkg::ex_uop_t    uop_i,
    output logic               idle_o,
    output logic               res_valid_o,
    output ex_pkg::ex_result_t result_o,
    input  logic               grant_i
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_EXEC,
        S_BUSY,
        S_DONE
    } lane_state_e;

    lane_state_e               state_q;
    ex_pkg::ex_uop_t           uop_q;
    ex_pkg::ex_result_t        result_d;
    logic [ex_pkg::DATA_W-1:0] alu_result;
    logic [ex_pkg::DATA_W-1:0] alu_addr;
    logic [ex_pkg::DATA_W-1:0] mul_product;
    logic                      alu_taken;
    logic                      mul_start;
    logic                      mul_done;
    logic                      is_mul;
    logic                      is_mem;
    logic                      is_csr;
    logic                      capture;

    // Operands go straight from the issue port so the multiplier loads on start
    assign mul_start = start_i
                    && (uop_i.op == ex_pkg::OP_MUL || uop_i.op == ex_pkg::OP_MULHU);

    assign is_mul = (uop_q.op == ex_pkg::OP_MUL) || (uop_q.op == ex_pkg::OP_MULHU);
    assign is_mem = (uop_q.op == ex_pkg::OP_LDW) || (uop_q.op == ex_pkg::OP_STW);
    assign is_csr = (uop_q.op == ex_pkg::OP_CSRXCHG);
    assign capture = (state_q == S_EXEC) || (state_q == S_BUSY && mul_done);

    alu u_alu (
        .op_i     (uop_q.op),
        .src1_i   (uop_q.src1),
        .src2_i   (uop_q.src2),
        .pc_i     (uop_q.pc),
        .aux_i    (uop_q.aux),
        .result_o (alu_result),
        .addr_o   (alu_addr),
        .taken_o  (alu_taken)
    );

    mul_unit u_mul_unit (
        .clk       (clk),
        .rst       (rst),
        .start_i   (mul_start),
        .high_i    (uop_q.op == ex_pkg::OP_MULHU),
        .a_i       (uop_i.src1),
        .b_i       (uop_i.src2),
        .done_o    (mul_done),
        .product_o (mul_product)
    );

    always_comb begin
        result_d          = '0;
        result_d.tag      = uop_q.tag;
        result_d.wdata    = is_mul ? mul_product : alu_result;
        if (is_mem) begin
            result_d.mem_addr = alu_addr;
            // Word access must be 4-byte aligned
            result_d.excp_ale = |alu_addr[1:0];
        end
        if (is_csr) begin
            result_d.wdata     = uop_q.csr_old;
            result_d.csr_we    = 1'b1;
            result_d.csr_addr  = uop_q.aux.csr.num;
            // src2 is the mask
            result_d.csr_wdata = (uop_q.src1 & uop_q.src2) | (~uop_q.src2 & uop_q.csr_old);
        end
        if (alu_taken) begin
            result_d.redirect        = 1'b1;
            result_d.redirect_target = alu_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= mul_start ? S_BUSY : S_EXEC;
                    end
                end
                S_EXEC: state_q <= S_DONE;
                S_BUSY: begin
                    if (mul_done) begin
                        state_q <= S_DONE;
                    end
                end
                S_DONE: begin
                    if (grant_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            uop_q <= uop_i;
        end
        if (capture) begin
            result_o <= result_d;
        end
    end

    assign idle_o      = (state_q == S_IDLE);
    assign res_valid_o = (state_q == S_DONE);

endmodule

// File: source/issue_dispatch.sv
`timescale 1ns/1ns

module issue_dispatch #(
    parameter int NUM_LANES = 3
) (
    input  logic                 issue_valid_i,
    input  ex_pkg::ex_uop_t      issue_uop_i,
    output logic                 issue_ready_o,
    input  logic [NUM_LANES-1:0] lane_idle_i,
    output logic [NUM_LANES-1:0] lane_start_o,
    output ex_pkg::ex_uop_t      lane_uop_o
);
    logic [NUM_LANES-1:0] lane_sel;
    logic                 found;

    // Lowest-numbered idle lane wins
    always_comb begin
        lane_sel = '0;
        found    = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lane_idle_i[i] && !found) begin
                lane_sel[i] = 1'b1;
                found       = 1'b1;
            end
        end
    end

    assign issue_ready_o = |lane_idle_i;

    // Ready already implies a selected lane
    assign lane_start_o = issue_valid_i ? lane_sel : '0;

    // All lanes see the same micro-op, only the started one latches it
    assign lane_uop_o = issue_uop_i;

endmodule

// File: source/result_arbiter.sv
`timescale 1ns/1ns

module result_arbiter #(
    parameter int NUM_LANES = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_LANES-1:0] res_valid_i,
    input  ex_pkg::ex_result_t   results_i [NUM_LANES],
    output logic [NUM_LANES-1:0] grant_o,
    output logic                 wb_valid_o,
    output ex_pkg::ex_result_t   wb_result_o,
    input  logic                 wb_ready_i
);
    logic [NUM_LANES-1:0] lane_sel;
    logic                 load;
    ex_pkg::ex_result_t   pick;

    // Output register refills only while the sink takes data
    assign load = wb_ready_i;

    always_comb begin
        lane_sel = '0;
        pick     = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (res_valid_i[i]) begin
                lane_sel = '0;
                lane_sel[i] = 1'b1;
                pick = results_i[i];
            end
        end
    end

    assign grant_o = load ? lane_sel : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
        end else if (load) begin
            wb_valid_o <= |res_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load && |res_valid_i) begin
            wb_result_o <= pick;
        end
    end

endmodule

// File: source/ex_cluster.sv
`timescale 1ns/1ns

module ex_cluster #(
    parameter int NUM_LANES = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid_i,
    input  ex_pkg::ex_uop_t    issue_uop_i,
    output logic               issue_ready_o,
    output logic               wb_valid_o,
    output ex_pkg::ex_result_t wb_result_o,
    input  logic               wb_ready_i
);
    logic [NUM_LANES-1:0] lane_start;
    logic [NUM_LANES-1:0] lane_idle;
    logic [NUM_LANES-1:0] res_valid;
    logic [NUM_LANES-1:0] res_grant;
    ex_pkg::ex_uop_t      lane_uop;
    ex_pkg::ex_result_t   lane_result [NUM_LANES];

    issue_dispatch #(.NUM_LANES(NUM_LANES)) u_issue_dispatch (
        .issue_valid_i (issue_valid_i),
        .issue_uop_i   (issue_uop_i),
        .issue_ready_o (issue_ready_o),
        .lane_idle_i   (lane_idle),
        .lane_start_o  (lane_start),
        .lane_uop_o    (lane_uop)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        ex_lane u_ex_lane (
            .clk         (clk),
            .rst         (rst),
            .start_i     (lane_start[i]),
            .uop_i       (lane_uop),
            .idle_o      (lane_idle[i]),
            .res_valid_o (res_valid[i]),
            .result_o    (lane_result[i]),
            .grant_i     (res_grant[i])
        );
    end

    result_arbiter #(.NUM_LANES(NUM_LANES)) u_result_arbiter (
        .clk         (clk),
        .rst         (rst),
        .res_valid_i (res_valid),
        .results_i   (lane_result),
        .grant_o     (res_grant),
        .wb_valid_o  (wb_valid_o),
        .wb_result_o (wb_result_o),
        .wb_ready_i  (wb_ready_i)
    );

endmodule

// File: tests/tb_ex_cluster.sv
`timescale 1ns/1ns

module tb_ex_cluster;

    localparam int NUM_LANES     = 3;
    localparam int NUM_PAT       = 16;
    localparam int PAT_WORDS     = 15;
    localparam int NUM_TAGS      = 2 ** ex_pkg::TAG_W;
    localparam int FILL_COUNT    = 5;
    localparam int READY_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 400;

    logic               clk;
    logic               rst;
    logic               issue_valid;
    ex_pkg::ex_uop_t    issue_uop;
    logic               issue_ready;
    logic               wb_valid;
    ex_pkg::ex_result_t wb_result;
    logic               wb_ready;

    logic [31:0]        pat_mem [NUM_PAT * PAT_WORDS];
    ex_pkg::ex_uop_t    uop_list [NUM_PAT];
    ex_pkg::ex_result_t exp_table [NUM_TAGS];
    logic               exp_valid [NUM_TAGS];
    logic               seen [NUM_TAGS];
    int                 seen_count;
    logic [31:0]        lfsr_q;

    ex_cluster #(.NUM_LANES(NUM_LANES)) u_ex_cluster (
        .clk           (clk),
        .rst           (rst),
        .issue_valid_i (issue_valid),
        .issue_uop_i   (issue_uop),
        .issue_ready_o (issue_ready),
        .wb_valid_o    (wb_valid),
        .wb_result_o   (wb_result),
        .wb_ready_i    (wb_ready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    //////////////////////////////
    // Random bits and error exit

    // Taps 32, 22, 2, 1
    function automatic int random_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            value  = (value << 1) | lfsr_q[0];
        end
        return value;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_result(input ex_pkg::ex_result_t got, input ex_pkg::ex_result_t want);
        if (got !== want) begin
            abort_run($sformatf("CHECK FAILED at %0t: tag %0h gave %h, expected %h",
                                $time, got.tag, got, want));
        end
    endtask

    task automatic check_ready(input logic got, input logic want, input string what);
        if (got !== want) begin
            abort_run($sformatf("CHECK FAILED at %0t: issue_ready is %b after %s, expected %b",
                                $time, got, what, want));
        end
    endtask

    //////////////////////////////
    // Pattern table and scoreboard
    task automatic load_patterns();
        int                 base;
        ex_pkg::ex_uop_t    uop;
        ex_pkg::ex_result_t res;
        $readmemh("tests/ex_patterns.txt", pat_mem);
        if ($isunknown(pat_mem[NUM_PAT * PAT_WORDS - 1])) begin
            abort_run("Pattern file holds fewer lines than expected");
        end else begin
            for (int t = 0; t < NUM_TAGS; t++) begin
                exp_valid[t] = 1'b0;
                seen[t]      = 1'b0;
            end
            for (int i = 0; i < NUM_PAT; i++) begin
                base                = i * PAT_WORDS;
                uop.tag             = pat_mem[base][ex_pkg::TAG_W-1:0];
                uop.op              = ex_pkg::ex_op_e'(pat_mem[base + 1][3:0]);
                uop.src1            = pat_mem[base + 2];
                uop.src2            = pat_mem[base + 3];
                uop.csr_old         = pat_mem[base + 4];
                uop.aux             = pat_mem[base + 5][11:0];
                uop.pc              = pat_mem[base + 6];
                res.tag             = uop.tag;
                res.wdata           = pat_mem[base + 7];
                res.mem_addr        = pat_mem[base + 8];
                res.excp_ale        = pat_mem[base + 9][0];
                res.csr_we          = pat_mem[base + 10][0];
                res.csr_addr        = pat_mem[base + 11][11:0];
                res.csr_wdata       = pat_mem[base + 12];
                res.redirect        = pat_mem[base + 13][0];
                res.redirect_target = pat_mem[base + 14];
                uop_list[i]         = uop;
                exp_table[uop.tag]  = res;
            end
        end
    endtask

    task automatic take_result(input ex_pkg::ex_result_t res);
        if (exp_valid[res.tag] !== 1'b1) begin
            abort_run($sformatf("Result with tag %0h was never issued", res.tag));
        end else if (seen[res.tag]) begin
            abort_run($sformatf("Result with tag %0h arrived twice", res.tag));
        end else begin
            check_result(res, exp_table[res.tag]);
            seen[res.tag] = 1'b1;
            seen_count++;
        end
    endtask

    // Writeback sink, one step per falling edge
    task automatic next_cycle();
        @(negedge clk);
        // Low about one cycle in four
        wb_ready = (random_bits(2) != 0);
        if (wb_valid && wb_ready) begin
            take_result(wb_result);
        end
    endtask

    task automatic issue_one(input ex_pkg::ex_uop_t uop);
        int waited;
        waited = 0;
        while (issue_ready !== 1'b1) begin
            if (waited >= READY_TIMEOUT) begin
                abort_run($sformatf("Timed out waiting for issue_ready, tag %0h", uop.tag));
            end else begin
                next_cycle();
                waited++;
            end
        end
        issue_valid        = 1'b1;
        issue_uop          = uop;
        exp_valid[uop.tag] = 1'b1;
        next_cycle();
        issue_valid = 1'b0;
    endtask

    //////////////////////////////
    // Main sequence
    initial begin
        int gap;
        int waited;
        lfsr_q      = 32'd85610;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue_uop   = '0;
        wb_ready    = 1'b1;
        seen_count  = 0;
        load_patterns();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        next_cycle();
        check_ready(issue_ready, 1'b1, "reset");

        // Back to back, so the multiplies at 0, 3 and 4 end up in all lanes
        for (int i = 0; i < FILL_COUNT; i++) begin
            issue_one(uop_list[i]);
        end
        check_ready(issue_ready, 1'b0, "three multiplies in flight");

        for (int i = FILL_COUNT; i < NUM_PAT; i++) begin
            gap = random_bits(2);
            repeat (gap) next_cycle();
            issue_one(uop_list[i]);
        end

        waited = 0;
        while (seen_count < NUM_PAT) begin
            if (waited >= DRAIN_TIMEOUT) begin
                abort_run($sformatf("Timed out draining results, %0d of %0d arrived",
                                    seen_count, NUM_PAT));
            end else begin
                next_cycle();
                waited++;
            end
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: tests/ex_patterns.txt
// Micro-op: tag op src1 src2 csr_old aux pc
// Expected: wdata mem_addr ale csr_we csr_addr csr_wdata redirect redirect_target
0 e 00012345 00000100 00000000 000 1c000000  01234500 00000000 0 0 000 00000000 0 00000000
1 0 7fffffff 00000001 00000000 000 1c000004  80000000 00000000 0 0 000 00000000 0 00000000
2 1 00000005 00000007 00000000 000 1c000008  fffffffe 00000000 0 0 000 00000000 0 00000000
3 f ffffffff ffffffff 00000000 000 1c00000c  fffffffe 00000000 0 0 000 00000000 0 00000000
4 e 0000ffff 00010001 00000000 000 1c000010  ffffffff 00000000 0 0 000 00000000 0 00000000
5 2 f0f0ff00 3c3c0ff0 00000000 000 1c000014  30300f00 00000000 0 0 000 00000000 0 00000000
6 4 aaaa5555 ffff0000 00000000 000 1c000018  55555555 00000000 0 0 000 00000000 0 00000000
7 5 00000013 00000024 00000000 000 1c00001c  00000130 00000000 0 0 000 00000000 0 00000000
8 6 80000000 0000001f 00000000 000 1c000020  00000001 00000000 0 0 000 00000000 0 00000000
9 7 fffffff0 00000001 00000000 000 1c000024  00000001 00000000 0 0 000 00000000 0 00000000
a 8 fffffff0 00000001 00000000 000 1c000028  00000000 00000000 0 0 000 00000000 0 00000000
b 9 00001000 12345678 00000000 ffc 1c00002c  00000ffc 00000000 0 0 000 00000000 0 00000000
c a 00002000 00000000 00000000 010 1c000030  00000000 00002010 0 0 000 00000000 0 00000000
d b 00002001 deadbeef 00000000 ffd 1c000034  00000000 00001ffe 1 0 000 00000000 0 00000000
e c 0000abcd 0000abcd 00000000 ff0 1c000038  00000000 00000000 0 0 000 00000000 1 1c000028
f d 12345678 0000ffff aaaaaaaa 180 1c00003c  aaaaaaaa 00000000 0 1 180 aaaa5678 0 00000000

// File: build.f
source/ex_pkg.sv
source/alu.sv
source/mul_unit.sv
source/ex_lane.sv
source/issue_dispatch.sv
source/result_arbiter.sv
source/ex_cluster.sv
tests/tb_ex_cluster.sv

// File: Bender.yml
package:
  name: ex_cluster

sources:
  - source/ex_pkg.sv
  - source/alu.sv
  - source/mul_unit.sv
  - source/ex_lane.sv
  - source/issue_dispatch.sv
  - source/result_arbiter.sv
  - source/ex_cluster.sv
  - target: test
    files:
      - tests/tb_ex_cluster.sv
